// File: vlog.f
src/cache_pkg.sv
src/request_classifier.sv
src/direct_mapped_cache.sv
src/memory_arbiter.sv
src/separate_caches.sv
tests/separate_caches_assertions.sv
tests/separate_caches_tb.sv

// File: Makefile
# Verilator build and run for the split cache testbench

LOG = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove build output and log"

test:
	verilator --binary --timing --assert -Wno-fatal \
		--top-module separate_caches_tb -Mdir obj_dir -f vlog.f
	./obj_dir/Vseparate_caches_tb | tee $(LOG)
	@grep -q "TEST PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: tests/separate_caches_tb.sv
// memory is sparse, unwritten words read as address ^ 32'h5a5aa5a5; one step runs at a time
`timescale 1ns/1ps

module separate_caches_tb;
    import cache_pkg::*;

    localparam int TIMEOUT = 200;
    localparam int P_I = 0, P_D = 1, P_BOTH = 2;
    localparam int OP_RD = 0, OP_WR = 1, OP_FLUSH = 2, OP_CLEAR = 3;

    typedef struct {
        string      name;
        int         port;
        int         op;
        word_t      addr;
        word_t      data;
        logic [3:0] be;
        word_t      exp;
        word_t      addr2;
        word_t      exp2;
        int         exp_miss;
        int         exp_acc;
    } step_t;

    logic CLK, reset;
    bus_req_t icache_req, dcache_req, mem_req;
    bus_rsp_t icache_rsp, dcache_rsp, mem_rsp;
    logic icache_flush, icache_clear, dcache_flush, dcache_clear;
    logic iflush_done, iclear_done, dflush_done, dclear_done, icache_miss, dcache_miss;

    word_t mem [word_t];
    word_t shadow [word_t];
    step_t steps [$];
    logic [31:0] rng = 32'hce13;
    logic pending;
    logic [1:0] delay_q;
    logic mem_busy;
    word_t mem_rdata;
    int mem_accesses = 0;
    int errors = 0;
    int timeouts = 0;

    separate_caches UUT (.*);

    initial begin
        CLK = 1'b0;
        forever #20 CLK = ~CLK;
    end

    function automatic logic [31:0] xorshift32(logic [31:0] s);
        s ^= s << 13;
        s ^= s >> 17;
        s ^= s << 5;
        return s;
    endfunction

    function automatic word_t pattern(word_t a);
        return a ^ 32'h5a5a_a5a5;
    endfunction

    // byte lanes picked by a full mask
    function automatic word_t apply_bytes(word_t old_w, word_t new_w, logic [3:0] be);
        word_t mask;
        mask = {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
        return (old_w & ~mask) | (new_w & mask);
    endfunction

    function automatic word_t mem_read(word_t a);
        return mem.exists(a) ? mem[a] : pattern(a);
    endfunction

    function automatic logic done_flag(bit on_i, bit is_flush);
        if (on_i) begin
            return is_flush ? iflush_done : iclear_done;
        end
        return is_flush ? dflush_done : dclear_done;
    endfunction

    // memory model: busy for 1 to 4 cycles, then one completing cycle
    assign mem_busy = (mem_req.ren || mem_req.wen) && (!pending || delay_q != 2'd0);
    assign mem_rsp = '{busy: mem_busy, rdata: mem_rdata};

    always @(posedge CLK) begin
        if (reset) begin
            pending <= 1'b0;
            delay_q <= 2'd0;
        end else if ((mem_req.ren || mem_req.wen) && !pending) begin
            rng = xorshift32(rng);
            pending   <= 1'b1;
            delay_q   <= rng[1:0];
            mem_rdata <= mem_read(mem_req.addr);
        end else if (pending && delay_q != 2'd0) begin
            delay_q <= delay_q - 2'd1;
        end else if (pending) begin
            pending <= 1'b0;
            mem_accesses++;
            if (mem_req.wen) begin
                mem[mem_req.addr] = apply_bytes(mem_read(mem_req.addr), mem_req.wdata,
                    mem_req.byte_en);
            end
        end
    end

    task automatic check_rsp(string name, word_t exp, word_t act);
        if (exp !== act) begin
            $display("ERROR %s: expected %h, actual %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_flag(string name, logic exp, logic act);
        if (exp !== act) begin
            $display("ERROR %s: expected %b, actual %b", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_count(string name, int exp, int act);
        if (exp != act) begin
            $display("ERROR %s: expected %0d, actual %0d", name, exp, act);
            errors++;
        end
    endtask

    task automatic run_access(bit on_i, string name, bit write, word_t addr, word_t data,
                              logic [3:0] be, word_t exp, int exp_miss);
        bus_req_t r;
        bus_rsp_t rsp;
        logic saw_miss;
        bit done;
        r = '{ren: !write, wen: write, addr: addr, wdata: data, byte_en: be};
        saw_miss = 1'b0;
        done = 1'b0;
        @(posedge CLK);
        if (on_i) icache_req <= r;
        else dcache_req <= r;
        for (int cyc = 0; cyc < TIMEOUT && !done; cyc++) begin
            @(negedge CLK);
            rsp = on_i ? icache_rsp : dcache_rsp;
            if (on_i ? icache_miss : dcache_miss) saw_miss = 1'b1;
            done = !rsp.busy;
        end
        if (!done) begin
            $display("%s: request was never accepted, busy stayed high", name);
            timeouts++;
        end else begin
            if (!write) check_rsp(name, exp, rsp.rdata);
            if (exp_miss != 2) check_flag({name, " miss"}, exp_miss[0], saw_miss);
        end
        @(posedge CLK);
        if (on_i) icache_req <= '0;
        else dcache_req <= '0;
    endtask

    task automatic apply_command(bit on_i, string name, bit is_flush);
        bit done;
        done = 1'b0;
        @(posedge CLK);
        if (on_i) begin
            icache_flush <= is_flush;
            icache_clear <= !is_flush;
        end else begin
            dcache_flush <= is_flush;
            dcache_clear <= !is_flush;
        end
        for (int cyc = 0; cyc < TIMEOUT && !done; cyc++) begin
            @(negedge CLK);
            done = done_flag(on_i, is_flush);
        end
        if (!done) begin
            $display("%s: done never went high", name);
            timeouts++;
        end
        @(posedge CLK);
        icache_flush <= 1'b0;
        icache_clear <= 1'b0;
        dcache_flush <= 1'b0;
        dcache_clear <= 1'b0;
        @(negedge CLK);
        check_flag({name, " done release"}, 1'b0, done_flag(on_i, is_flush));
    endtask

    initial begin
        #(40 * 20000);
        $display("watchdog expired, the run did not finish");
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        reset = 1'b1;
        icache_req = '0;
        dcache_req = '0;
        icache_flush = 1'b0;
        icache_clear = 1'b0;
        dcache_flush = 1'b0;
        dcache_clear = 1'b0;

        // name port op addr data be exp addr2 exp2 miss(2=any) accesses(-1=any)
        steps.push_back('{"i_fill", P_I, OP_RD, 32'h100, 0, 4'hf, pattern(32'h100), 0, 0, 1, -1});
        steps.push_back('{"i_hit", P_I, OP_RD, 32'h104, 0, 4'hf, pattern(32'h104), 0, 0, 0, -1});
        steps.push_back('{"i_flush", P_I, OP_FLUSH, 0, 0, 0, 0, 0, 0, 2, 0});
        steps.push_back('{"i_clear", P_I, OP_CLEAR, 0, 0, 0, 0, 0, 0, 2, 0});
        steps.push_back('{"i_refill", P_I, OP_RD, 32'h100, 0, 4'hf, pattern(32'h100), 0, 0,
                          1, -1});
        steps.push_back('{"d_part_wr", P_D, OP_WR, 32'h208, 32'hdead_beef, 4'b0011, 0, 0, 0,
                          2, -1});
        steps.push_back('{"d_part_rd", P_D, OP_RD, 32'h208, 0, 4'hf,
                          apply_bytes(pattern(32'h208), 32'hdead_beef, 4'b0011), 0, 0, 0, -1});
        steps.push_back('{"unc_wr", P_D, OP_WR, 32'h8000_0010, 32'h1234_5678, 4'hf, 0, 0, 0,
                          0, 1});
        steps.push_back('{"unc_rd", P_D, OP_RD, 32'h8000_0010, 0, 4'hf, 32'h1234_5678, 0, 0,
                          0, 1});
        steps.push_back('{"d_dirty", P_D, OP_WR, 32'h310, 32'hcafe_f00d, 4'hf, 0, 0, 0, 2, -1});
        // two dirty lines, two words each
        steps.push_back('{"d_flush", P_D, OP_FLUSH, 0, 0, 0, 0, 0, 0, 2, 4});
        steps.push_back('{"after_flush", P_D, OP_RD, 32'h310, 0, 4'hf, 32'hcafe_f00d, 0, 0,
                          0, -1});
        steps.push_back('{"d_lost", P_D, OP_WR, 32'h420, 32'h0bad_cafe, 4'hf, 0, 0, 0, 2, -1});
        steps.push_back('{"d_clear", P_D, OP_CLEAR, 0, 0, 0, 0, 0, 0, 2, 0});
        steps.push_back('{"after_clear", P_D, OP_RD, 32'h420, 0, 4'hf, pattern(32'h420), 0, 0,
                          1, -1});
        steps.push_back('{"both_miss", P_BOTH, OP_RD, 32'h530, 0, 4'hf, pattern(32'h530),
                          32'h648, pattern(32'h648), 1, 4});

        repeat (10) @(posedge CLK);
        reset <= 1'b0;

        foreach (steps[k]) begin
            step_t s;
            int acc0;
            s = steps[k];
            acc0 = mem_accesses;
            case (s.op)
                OP_FLUSH: begin
                    apply_command(s.port == P_I, s.name, 1'b1);
                    // written back words must match the expected image
                    foreach (shadow[a]) check_rsp({s.name, " memory"}, shadow[a], mem_read(a));
                end
                OP_CLEAR: apply_command(s.port == P_I, s.name, 1'b0);
                default: begin
                    if (s.port == P_BOTH) begin
                        fork
                            run_access(1'b1, {s.name, " i"}, 1'b0, s.addr, 0, 4'hf, s.exp,
                                       s.exp_miss);
                            run_access(1'b0, {s.name, " d"}, 1'b0, s.addr2, 0, 4'hf, s.exp2,
                                       s.exp_miss);
                        join
                    end else begin
                        run_access(s.port == P_I, s.name, s.op == OP_WR, s.addr, s.data, s.be,
                                   s.exp, s.exp_miss);
                    end
                    if (s.op == OP_WR) begin
                        shadow[s.addr] = apply_bytes(shadow.exists(s.addr) ? shadow[s.addr] :
                                                     pattern(s.addr), s.data, s.be);
                    end
                end
            endcase
            if (s.exp_acc >= 0) check_count({s.name, " accesses"}, s.exp_acc, mem_accesses - acc0);
        end

        repeat (4) @(posedge CLK);
        $display("errors: %0d value mismatches, %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: tests/separate_caches_assertions.sv
// bound to the arbiter and both caches; command and miss checks run on the caches only
`timescale 1ns/1ps

module separate_caches_assertions #(
    parameter bit CACHE_SIDE = 1'b1
) (
    input logic                CLK,
    input logic                reset,
    input cache_pkg::bus_req_t mem_req,
    input cache_pkg::bus_rsp_t mem_rsp,
    input logic                flush,
    input logic                clear,
    input logic                flush_done,
    input logic                clear_done,
    input logic                miss
);
    // a stalled request must not move
    a_req_stable: assert property (@(posedge CLK) disable iff (reset)
        ((mem_req.ren || mem_req.wen) && mem_rsp.busy) |=> $stable(mem_req))
        else $error("memory request changed while busy was high");

    a_one_dir: assert property (@(posedge CLK) disable iff (reset)
        !(mem_req.ren && mem_req.wen))
        else $error("memory request has ren and wen high together");

    // command handshake and miss exist only on a cache
    if (CACHE_SIDE) begin : g_cache
        // done holds for as long as its command does
        a_flush_done: assert property (@(posedge CLK) disable iff (reset)
            (flush_done && flush) |=> (flush_done || !flush))
            else $error("flush done dropped while the flush command was still high");

        a_clear_done: assert property (@(posedge CLK) disable iff (reset)
            (clear_done && clear) |=> (clear_done || !clear))
            else $error("clear done dropped while the clear command was still high");

        // no miss in the first cycle after reset
        a_no_miss: assert property (@(posedge CLK) reset |=> !miss)
            else $error("miss is high right after reset");
    end

endmodule

bind memory_arbiter separate_caches_assertions #(.CACHE_SIDE(1'b0)) arb_chk (
    .CLK(CLK), .reset(reset), .mem_req(mem_req), .mem_rsp(mem_rsp), .flush(1'b0),
    .clear(1'b0), .flush_done(1'b0), .clear_done(1'b0), .miss(1'b0)
);

bind direct_mapped_cache separate_caches_assertions cache_chk (
    .CLK(CLK), .reset(reset), .mem_req(mem_req), .mem_rsp(mem_rsp), .flush(flush),
    .clear(clear), .flush_done(flush_done), .clear_done(clear_done), .miss(cache_miss)
);

// File: src/separate_caches.sv
// split l1 caches, direct mapped only; no translation, no coherence
`timescale 1ns/1ps

module separate_caches (
    input  logic                CLK,
    input  logic                reset,
    input  cache_pkg::bus_req_t icache_req,
    input  cache_pkg::bus_req_t dcache_req,
    input  cache_pkg::bus_rsp_t mem_rsp,
    input  logic                icache_flush,
    input  logic                icache_clear,
    input  logic                dcache_flush,
    input  logic                dcache_clear,
    output cache_pkg::bus_rsp_t icache_rsp,
    output cache_pkg::bus_rsp_t dcache_rsp,
    output cache_pkg::bus_req_t mem_req,
    output logic                iflush_done,
    output logic                iclear_done,
    output logic                dflush_done,
    output logic                dclear_done,
    output logic                icache_miss,
    output logic                dcache_miss
);
    import cache_pkg::*;

    cls_req_t icache_cls;
    cls_req_t dcache_cls;
    bus_req_t icache_mem_req;
    bus_req_t dcache_mem_req;
    bus_rsp_t icache_mem_rsp;
    bus_rsp_t dcache_mem_rsp;

    request_classifier i_classifier (
        .req (icache_req),
        .cls (icache_cls)
    );

    request_classifier d_classifier (
        .req (dcache_req),
        .cls (dcache_cls)
    );

    // instruction cache, read only
    direct_mapped_cache #(.IS_ICACHE(1'b1)) icache (
        .CLK        (CLK),
        .reset      (reset),
        .cls        (icache_cls),
        .flush      (icache_flush),
        .clear      (icache_clear),
        .mem_rsp    (icache_mem_rsp),
        .proc_rsp   (icache_rsp),
        .mem_req    (icache_mem_req),
        .flush_done (iflush_done),
        .clear_done (iclear_done),
        .cache_miss (icache_miss)
    );

    direct_mapped_cache #(.IS_ICACHE(1'b0)) dcache (
        .CLK        (CLK),
        .reset      (reset),
        .cls        (dcache_cls),
        .flush      (dcache_flush),
        .clear      (dcache_clear),
        .mem_rsp    (dcache_mem_rsp),
        .proc_rsp   (dcache_rsp),
        .mem_req    (dcache_mem_req),
        .flush_done (dflush_done),
        .clear_done (dclear_done),
        .cache_miss (dcache_miss)
    );

    memory_arbiter arbiter (
        .CLK     (CLK),
        .reset   (reset),
        .d_req   (dcache_mem_req),
        .i_req   (icache_mem_req),
        .mem_rsp (mem_rsp),
        .d_rsp   (dcache_mem_rsp),
        .i_rsp   (icache_mem_rsp),
        .mem_req (mem_req)
    );

endmodule

// File: src/memory_arbiter.sv
// one memory port; a grant holds while the owner keeps ren or wen high, data side wins ties
`timescale 1ns/1ps

module memory_arbiter (
    input  logic                CLK,
    input  logic                reset,
    input  cache_pkg::bus_req_t d_req,
    input  cache_pkg::bus_req_t i_req,
    input  cache_pkg::bus_rsp_t mem_rsp,
    output cache_pkg::bus_rsp_t d_rsp,
    output cache_pkg::bus_rsp_t i_rsp,
    output cache_pkg::bus_req_t mem_req
);
    import cache_pkg::*;

    logic d_act;
    logic i_act;
    logic locked;
    logic gnt_i_q;
    logic owner_act;
    logic sel_i;

    assign d_act = d_req.ren | d_req.wen;
    assign i_act = i_req.ren | i_req.wen;

    // owner still in its sequence
    assign owner_act = locked && (gnt_i_q ? i_act : d_act);

    // fresh choice as soon as the owner lets go
    always_comb begin
        if (owner_act) begin
            sel_i = gnt_i_q;
        end else begin
            sel_i = i_act && !d_act;
        end
    end

    always_ff @(posedge CLK) begin
        if (reset) begin
            locked  <= 1'b0;
            gnt_i_q <= 1'b0;
        end else begin
            locked  <= sel_i ? i_act : d_act;
            gnt_i_q <= sel_i;
        end
    end

    assign mem_req = sel_i ? i_req : d_req;

    // losing side is stalled, idle side is never busy
    always_comb begin
        d_rsp.rdata = mem_rsp.rdata;
        i_rsp.rdata = mem_rsp.rdata;
        d_rsp.busy  = d_act && (sel_i || mem_rsp.busy);
        i_rsp.busy  = i_act && (!sel_i || mem_rsp.busy);
    end

endmodule

// File: src/direct_mapped_cache.sv
// direct mapped, write-back/write-allocate; flush and clear start only from idle, requests wait
`timescale 1ns/1ps

module direct_mapped_cache #(
    parameter bit IS_ICACHE = 1'b0
) (
    input  logic                CLK,
    input  logic                reset,
    input  cache_pkg::cls_req_t cls,
    input  logic                flush,
    input  logic                clear,
    input  cache_pkg::bus_rsp_t mem_rsp,
    output cache_pkg::bus_rsp_t proc_rsp,
    output cache_pkg::bus_req_t mem_req,
    output logic                flush_done,
    output logic                clear_done,
    output logic                cache_miss
);
    import cache_pkg::*;

    typedef enum logic [3:0] {
        IDLE, COMPARE, WRITEBACK, FILL, UNCACHED, UNC_DONE,
        FLUSH_WALK, FLUSH_WB, FLUSH_DONE, CLEAR_WALK, CLEAR_DONE
    } state_t;

    state_t state;

    // line state and storage
    logic [LINES-1:0] valid;
    logic [LINES-1:0] dirty;
    logic [TAG_W-1:0] tag_arr  [LINES];
    word_t            data_arr [LINES][BLOCK_WORDS];

    logic [OFFSET_W-1:0] word_cnt;
    logic [INDEX_W-1:0]  walk_idx;
    logic [INDEX_W-1:0]  wb_line;
    word_t               unc_rdata;

    logic rd, wr, active, hit, word_last, walk_last;
    logic fill_we, fill_last, hit_we, unc_we, wb_step;

    function automatic word_t merge_bytes(word_t old_w, word_t new_w, logic [3:0] be);
        word_t res;
        res = old_w;
        for (int b = 0; b < 4; b++) begin
            if (be[b]) begin
                res[8*b +: 8] = new_w[8*b +: 8];
            end
        end
        return res;
    endfunction

    // instruction side never writes
    assign rd     = cls.req.ren;
    assign wr     = cls.req.wen & ~IS_ICACHE;
    assign active = rd | wr;

    assign hit       = valid[cls.index] && (tag_arr[cls.index] == cls.tag);
    assign word_last = (word_cnt == OFFSET_W'(BLOCK_WORDS - 1));
    assign walk_last = (walk_idx == INDEX_W'(LINES - 1));

    // write-back victim comes from the walk during a flush
    assign wb_line = (state == FLUSH_WB) ? walk_idx : cls.index;

    assign fill_we   = (state == FILL) && !mem_rsp.busy;
    assign fill_last = fill_we && word_last;
    assign hit_we    = (state == COMPARE) && hit && wr;
    assign unc_we    = (state == UNCACHED) && !mem_rsp.busy;
    assign wb_step   = ((state == WRITEBACK) || (state == FLUSH_WB)) && !mem_rsp.busy;

    always_ff @(posedge CLK) begin
        if (fill_we) begin
            data_arr[cls.index][word_cnt] <= mem_rsp.rdata;
        end
        if (fill_last) begin
            tag_arr[cls.index] <= cls.tag;
        end
        if (hit_we) begin
            data_arr[cls.index][cls.offset] <=
                merge_bytes(data_arr[cls.index][cls.offset], cls.req.wdata, cls.req.byte_en);
        end
        if (unc_we) begin
            unc_rdata <= mem_rsp.rdata;
        end
    end

    always_ff @(posedge CLK) begin
        if (reset) begin
            state    <= IDLE;
            valid    <= '0;
            dirty    <= '0;
            word_cnt <= '0;
            walk_idx <= '0;
        end else begin
            if (fill_last) begin
                valid[cls.index] <= 1'b1;
                dirty[cls.index] <= 1'b0;
            end
            if (hit_we) begin
                dirty[cls.index] <= 1'b1;
            end
            if (wb_step) begin
                word_cnt <= word_cnt + 1'b1;
            end
            if (fill_we) begin
                word_cnt <= word_cnt + 1'b1;
            end

            case (state)
                IDLE: begin
                    walk_idx <= '0;
                    word_cnt <= '0;
                    if (flush) begin
                        state <= FLUSH_WALK;
                    end else if (clear) begin
                        state <= CLEAR_WALK;
                    end else if (active) begin
                        state <= cls.uncached ? UNCACHED : COMPARE;
                    end
                end
                COMPARE: begin
                    word_cnt <= '0;
                    if (hit) begin
                        state <= IDLE;
                    end else if (valid[cls.index] && dirty[cls.index]) begin
                        state <= WRITEBACK;
                    end else begin
                        state <= FILL;
                    end
                end
                WRITEBACK: begin
                    if (wb_step && word_last) begin
                        state <= FILL;
                    end
                end
                FILL: begin
                    // request finishes through the hit path
                    if (fill_last) begin
                        state <= COMPARE;
                    end
                end
                UNCACHED: begin
                    if (unc_we) begin
                        state <= UNC_DONE;
                    end
                end
                UNC_DONE: begin
                    state <= IDLE;
                end
                FLUSH_WALK: begin
                    word_cnt <= '0;
                    if (valid[walk_idx] && dirty[walk_idx]) begin
                        state <= FLUSH_WB;
                    end else if (walk_last) begin
                        state <= FLUSH_DONE;
                    end else begin
                        walk_idx <= walk_idx + 1'b1;
                    end
                end
                FLUSH_WB: begin
                    // line stays valid, only the dirty bit goes
                    if (wb_step && word_last) begin
                        dirty[walk_idx] <= 1'b0;
                        if (walk_last) begin
                            state <= FLUSH_DONE;
                        end else begin
                            walk_idx <= walk_idx + 1'b1;
                            state    <= FLUSH_WALK;
                        end
                    end
                end
                CLEAR_WALK: begin
                    valid[walk_idx] <= 1'b0;
                    dirty[walk_idx] <= 1'b0;
                    walk_idx        <= walk_idx + 1'b1;
                    if (walk_last) begin
                        state <= CLEAR_DONE;
                    end
                end
                FLUSH_DONE: begin
                    if (!flush) begin
                        state <= IDLE;
                    end
                end
                CLEAR_DONE: begin
                    if (!clear) begin
                        state <= IDLE;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // memory side request
    always_comb begin
        mem_req = '0;
        case (state)
            WRITEBACK, FLUSH_WB: begin
                mem_req.wen     = 1'b1;
                mem_req.addr    = {tag_arr[wb_line], wb_line, word_cnt, 2'b00};
                mem_req.wdata   = data_arr[wb_line][word_cnt];
                mem_req.byte_en = 4'hf;
            end
            FILL: begin
                mem_req.ren     = 1'b1;
                mem_req.addr    = {cls.tag, cls.index, word_cnt, 2'b00};
                mem_req.byte_en = 4'hf;
            end
            UNCACHED: begin
                mem_req.ren     = rd;
                mem_req.wen     = wr;
                mem_req.addr    = cls.req.addr;
                mem_req.wdata   = cls.req.wdata;
                mem_req.byte_en = cls.req.byte_en;
            end
            default: begin
                mem_req = '0;
            end
        endcase
    end

    // busy follows the request except in the completing cycle
    always_comb begin
        proc_rsp.busy  = active;
        proc_rsp.rdata = data_arr[cls.index][cls.offset];
        if (state == COMPARE && hit) begin
            proc_rsp.busy = 1'b0;
        end else if (state == UNC_DONE) begin
            proc_rsp.busy  = 1'b0;
            proc_rsp.rdata = unc_rdata;
        end
    end

    assign cache_miss = (state == FILL);
    assign flush_done = (state == FLUSH_DONE) && flush;
    assign clear_done = (state == CLEAR_DONE) && clear;

endmodule

// File: src/request_classifier.sv
// purely combinational; a request with both ren and wen high is handled as a write only
`timescale 1ns/1ps

module request_classifier (
    input  cache_pkg::bus_req_t req,
    output cache_pkg::cls_req_t cls
);
    import cache_pkg::*;

    logic  is_write;
    word_t word_addr;

    // write wins over read
    assign is_write = req.wen;

    // byte offset is ignored, accesses are word sized
    assign word_addr = {req.addr[31:2], 2'b00};

    always_comb begin
        cls.req.ren     = req.ren & ~is_write;
        cls.req.wen     = is_write;
        cls.req.addr    = word_addr;
        cls.req.wdata   = req.wdata;
        cls.req.byte_en = req.byte_en;

        // io region above the boundary is never allocated
        cls.uncached = (word_addr >= NONCACHE_START_ADDR);

        // field split for the tag and data arrays
        cls.tag    = word_addr[31 -: TAG_W];
        cls.index  = word_addr[2 + OFFSET_W +: INDEX_W];
        cls.offset = word_addr[2 +: OFFSET_W];
    end

endmodule

// File: src/cache_pkg.sv
// geometry is fixed at build time; LINES and BLOCK_WORDS must be powers of two, BLOCK_WORDS >= 2
package cache_pkg;

    // plain 32-bit data or address word
    typedef logic [31:0] word_t;

    // cache geometry
    localparam int LINES       = 16;
    localparam int BLOCK_WORDS = 2;

    // address split: tag | index | word offset | byte offset
    localparam int INDEX_W  = $clog2(LINES);
    localparam int OFFSET_W = $clog2(BLOCK_WORDS);
    localparam int TAG_W    = 32 - INDEX_W - OFFSET_W - 2;

    // everything at or above this address bypasses the caches
    localparam word_t NONCACHE_START_ADDR = 32'h8000_0000;

    // requester side of a bus port, held until busy is low
    typedef struct packed {
        logic       ren;
        logic       wen;
        word_t      addr;
        word_t      wdata;
        logic [3:0] byte_en;
    } bus_req_t;

    // responder side of a bus port
    typedef struct packed {
        logic  busy;
        word_t rdata;
    } bus_rsp_t;

    // request after classification
    typedef struct packed {
        bus_req_t            req;
        logic                uncached;
        logic [TAG_W-1:0]    tag;
        logic [INDEX_W-1:0]  index;
        logic [OFFSET_W-1:0] offset;
    } cls_req_t;

endpackage
